//--- src.f
+incdir+source
source/bilinear_pkg.sv
source/texel_rd_if.sv
source/bilinear_cfg.sv
source/bilinear_fetch.sv
source/texel_ram.sv
source/bilinear_accum.sv
source/bilinear_top.sv
dv/bilinear_assert.sv
dv/bilinear_tb.sv

//--- Bender.yml
package:
  name: bilinear_sampler

sources:
  - include_dirs:
      - source
    files:
      - source/bilinear_pkg.sv
      - source/texel_rd_if.sv
      - source/bilinear_cfg.sv
      - source/bilinear_fetch.sv
      - source/texel_ram.sv
      - source/bilinear_accum.sv
      - source/bilinear_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/bilinear_assert.sv
      - dv/bilinear_tb.sv

//--- dv/bilinear_tb.sv
/*
 * Table-driven testbench for the bilinear texture sampler.
 * Fills the image memory with random texels, then for each table row
 * programs the registers, sends the samples and compares the pixels.
 */

`include "bilinear_params.svh"

module bilinear_tb;
	import bilinear_pkg::*;

	localparam int TIMEOUT = 100;
	localparam int SIDE = 1 << `BL_INT_WIDTH;
	localparam int W_ONE = 1 << `BL_FRAC_WIDTH;

	typedef struct {
		string name;
		logic [`BL_COORD_WIDTH-1:0] x;
		logic [`BL_COORD_WIDTH-1:0] y;
		logic [`BL_USER_WIDTH-1:0] tag;
		int num;
		logic [`BL_INT_WIDTH:0] width;
		logic [`BL_INT_WIDTH:0] height;
		border_mode_t border;
		bit toggle;
	} test_row_t;

	logic clk;
	logic reset;
	logic [`BL_COORD_WIDTH-1:0] s_x;
	logic [`BL_COORD_WIDTH-1:0] s_y;
	logic [`BL_USER_WIDTH-1:0] s_user;
	logic s_valid;
	logic s_ready;
	logic [`BL_PIXEL_WIDTH-1:0] m_data;
	logic [`BL_USER_WIDTH-1:0] m_user;
	logic m_valid;
	logic m_ready;
	logic cfg_we;
	cfg_reg_t cfg_sel;
	logic [`BL_INT_WIDTH:0] cfg_wdata;
	logic tex_we;
	logic [`BL_INT_WIDTH-1:0] tex_x;
	logic [`BL_INT_WIDTH-1:0] tex_y;
	logic [`BL_PIXEL_WIDTH-1:0] tex_wdata;

	logic [`BL_PIXEL_WIDTH-1:0] tex [SIDE][SIDE];
	test_row_t tests [$];
	int error_count;
	bit timed_out;

	bilinear_top dut0 (
		.clk(clk), .reset(reset),
		.s_x(s_x), .s_y(s_y), .s_user(s_user), .s_valid(s_valid), .s_ready(s_ready),
		.m_data(m_data), .m_user(m_user), .m_valid(m_valid), .m_ready(m_ready),
		.cfg_we(cfg_we), .cfg_sel(cfg_sel), .cfg_wdata(cfg_wdata),
		.tex_we(tex_we), .tex_x(tex_x), .tex_y(tex_y), .tex_wdata(tex_wdata)
	);

	always #10 clk = ~clk;

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic logic [`BL_PIXEL_WIDTH-1:0] texel_at(int nx, int ny, int w, int h,
		border_mode_t border);
		int cx;
		int cy;
		if ((nx >= w || ny >= h) && border == BORDER_ZERO) begin
			return '0;
		end
		// clamp repeats the last column or row
		cx = (nx >= w) ? w - 1 : nx;
		cy = (ny >= h) ? h - 1 : ny;
		return tex[cy][cx];
	endfunction

	function automatic logic [`BL_PIXEL_WIDTH-1:0] expected_pixel(
		logic [`BL_COORD_WIDTH-1:0] x, logic [`BL_COORD_WIDTH-1:0] y,
		int w, int h, border_mode_t border);
		int xi;
		int yi;
		int xf;
		int yf;
		int weight;
		int acc;
		logic [`BL_PIXEL_WIDTH-1:0] t;
		logic [`BL_PIXEL_WIDTH-1:0] pix;
		xi = x >> `BL_FRAC_WIDTH;
		yi = y >> `BL_FRAC_WIDTH;
		xf = x % W_ONE;
		yf = y % W_ONE;
		for (int c = 0; c < `BL_COMP_NUM; c++) begin
			acc = 0;
			for (int dy = 0; dy < 2; dy++) begin
				for (int dx = 0; dx < 2; dx++) begin
					weight = (dx ? xf : W_ONE - xf) * (dy ? yf : W_ONE - yf);
					t = texel_at(xi + dx, yi + dy, w, h, border);
					acc += int'(t[c*`BL_DATA_WIDTH +: `BL_DATA_WIDTH]) * weight;
				end
			end
			pix[c*`BL_DATA_WIDTH +: `BL_DATA_WIDTH] = acc / (W_ONE * W_ONE);
		end
		return pix;
	endfunction

	// burst samples step through the image
	function automatic logic [7:0] burst_step(logic [7:0] base, int i, int step);
		return base + 8'(i * step);
	endfunction

	// --------------------------------------------------
	// drivers and checks
	// --------------------------------------------------
	task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s = %h, expected %h", $time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic write_reg(cfg_reg_t sel, logic [`BL_INT_WIDTH:0] data);
		cfg_we = 1'b1;
		cfg_sel = sel;
		cfg_wdata = data;
		@(posedge clk);
		#2;
		cfg_we = 1'b0;
	endtask

	task automatic add_test(string name, logic [7:0] x, logic [7:0] y, logic [7:0] tag,
		int num, logic [4:0] width, logic [4:0] height, border_mode_t border, bit toggle);
		test_row_t row;
		row = '{name, x, y, tag, num, width, height, border, toggle};
		tests.push_back(row);
	endtask

	task automatic send_samples(int idx);
		int waited;
		bit sent;
		for (int i = 0; i < tests[idx].num && !timed_out; i++) begin
			s_x = burst_step(tests[idx].x, i, 29);
			s_y = burst_step(tests[idx].y, i, 23);
			s_user = tests[idx].tag + 8'(i);
			s_valid = 1'b1;
			waited = 0;
			sent = 0;
			// s_ready seen mid-cycle means the next edge transfers
			while (!sent && !timed_out) begin
				@(negedge clk);
				if (s_ready) begin
					sent = 1;
				end else begin
					waited++;
					if (waited >= TIMEOUT) begin
						$display("timeout: sample %0d of test %s was never accepted",
							i, tests[idx].name);
						timed_out = 1;
						error_count++;
					end
				end
				@(posedge clk);
				#2;
			end
		end
		s_valid = 1'b0;
	endtask

	task automatic collect_pixels(int idx);
		int waited;
		bit got;
		logic [`BL_PIXEL_WIDTH-1:0] exp_data;
		for (int i = 0; i < tests[idx].num && !timed_out; i++) begin
			exp_data = expected_pixel(burst_step(tests[idx].x, i, 29),
				burst_step(tests[idx].y, i, 23), tests[idx].width, tests[idx].height,
				tests[idx].border);
			waited = 0;
			got = 0;
			while (!got && !timed_out) begin
				m_ready = tests[idx].toggle ? 1'($urandom % 2) : 1'b1;
				@(negedge clk);
				if (m_valid && m_ready) begin
					got = 1;
					check_value("m_data", 32'(m_data), 32'(exp_data));
					check_value("m_user", 32'(m_user), 32'(tests[idx].tag + 8'(i)));
				end else begin
					waited++;
					if (waited >= TIMEOUT) begin
						$display("timeout: pixel %0d of test %s never arrived",
							i, tests[idx].name);
						timed_out = 1;
						error_count++;
					end
				end
				@(posedge clk);
				#2;
			end
		end
	endtask

	// no pixel may follow the last expected one
	task automatic check_drained(int idx);
		repeat (8) begin
			@(negedge clk);
			if (m_valid) begin
				$display("extra pixel with tag %h after test %s", m_user, tests[idx].name);
				error_count++;
			end
			@(posedge clk);
			#2;
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		int errors_before;
		int tests_failed;
		int assert_seen;
		clk = 1'b0;
		reset = 1'b1;
		s_x = '0;
		s_y = '0;
		s_user = '0;
		s_valid = 1'b0;
		m_ready = 1'b1;
		cfg_we = 1'b0;
		cfg_sel = REG_WIDTH;
		cfg_wdata = '0;
		tex_we = 1'b0;
		tex_x = '0;
		tex_y = '0;
		tex_wdata = '0;
		error_count = 0;
		tests_failed = 0;
		assert_seen = 0;
		timed_out = 0;
		void'($urandom(32'h0863_8e59));

		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		// random texture written to the memory and the model copy
		for (int y = 0; y < SIDE; y++) begin
			for (int x = 0; x < SIDE; x++) begin
				tex[y][x] = `BL_PIXEL_WIDTH'($urandom);
				tex_we = 1'b1;
				tex_x = x;
				tex_y = y;
				tex_wdata = tex[y][x];
				@(posedge clk);
				#2;
			end
		end
		tex_we = 1'b0;

		add_test("integer", 8'h30, 8'h50, 8'h11, 1, 16, 16, BORDER_CLAMP, 0);
		add_test("integer_last", 8'hf0, 8'hf0, 8'h12, 1, 16, 16, BORDER_CLAMP, 0);
		add_test("fraction", 8'h57, 8'h2c, 8'h21, 1, 16, 16, BORDER_CLAMP, 0);
		add_test("fraction_mid", 8'ha8, 8'h68, 8'h22, 1, 16, 16, BORDER_CLAMP, 0);
		add_test("clamp_edge", 8'hf8, 8'hf4, 8'h31, 1, 16, 16, BORDER_CLAMP, 0);
		add_test("clamp_reduced", 8'h9b, 8'h76, 8'h32, 1, 10, 7, BORDER_CLAMP, 0);
		add_test("zero_edge", 8'hf8, 8'h30, 8'h41, 1, 16, 16, BORDER_ZERO, 0);
		add_test("zero_reduced", 8'h58, 8'h46, 8'h42, 1, 6, 5, BORDER_ZERO, 0);
		add_test("burst", 8'h13, 8'h21, 8'h80, 12, 16, 16, BORDER_CLAMP, 1);
		add_test("burst_zero", 8'h47, 8'h85, 8'hc0, 8, 12, 9, BORDER_ZERO, 1);

		for (int t = 0; t < tests.size() && !timed_out; t++) begin
			errors_before = error_count;
			write_reg(REG_WIDTH, tests[t].width);
			write_reg(REG_HEIGHT, tests[t].height);
			write_reg(REG_BORDER, {4'b0, tests[t].border});
			fork
				send_samples(t);
				collect_pixels(t);
			join
			m_ready = 1'b1;
			check_drained(t);
			// handshake assertion failures count against this test
			error_count += dut0.assert0.fail_count - assert_seen;
			assert_seen = dut0.assert0.fail_count;
			if (error_count != errors_before) begin
				tests_failed++;
				$display("test %s: failed with %0d errors", tests[t].name,
					error_count - errors_before);
			end else begin
				$display("test %s: ok, %0d pixels", tests[t].name, tests[t].num);
			end
		end

		$display("tests %0d, failed %0d, errors %0d", tests.size(), tests_failed, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- dv/bilinear_assert.sv
/*
 * Handshake assertions for the bilinear sampler top level.
 * Bound to bilinear_top, and reaches the texel read request through the
 * interface instance inside it.
 */

`include "bilinear_params.svh"

module bilinear_assert (
	input logic clk,
	input logic reset,
	input logic s_ready,
	input logic m_valid,
	input logic m_ready,
	input logic [`BL_PIXEL_WIDTH-1:0] m_data,
	input logic [`BL_USER_WIDTH-1:0] m_user,
	input logic rq_valid,
	input logic rq_ready,
	input logic [`BL_INT_WIDTH:0] rq_x,
	input logic [`BL_INT_WIDTH:0] rq_y,
	input logic [`BL_COEFF_WIDTH-1:0] rq_coeff,
	input logic [1:0] rq_corner
);

	// number of failed assertions
	int fail_count = 0;

	// output register is cleared by the reset
	m_valid_reset: assert property (@(posedge clk) reset |=> !m_valid)
		else begin
			$error("m_valid high during reset");
			fail_count++;
		end

	// held pixel under back-pressure
	m_hold: assert property (@(posedge clk) disable iff (reset)
		m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_user))
		else begin
			$error("pixel output changed while m_ready was low");
			fail_count++;
		end

	rq_hold: assert property (@(posedge clk) disable iff (reset)
		rq_valid && !rq_ready |=> rq_valid && $stable(rq_x) && $stable(rq_y)
			&& $stable(rq_coeff) && $stable(rq_corner))
		else begin
			$error("texel request dropped or changed before rq_ready");
			fail_count++;
		end

	s_ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> s_ready)
		else begin
			$error("s_ready low when reset ended");
			fail_count++;
		end

endmodule

bind bilinear_top bilinear_assert assert0 (
	.clk(clk), .reset(reset), .s_ready(s_ready),
	.m_valid(m_valid), .m_ready(m_ready), .m_data(m_data), .m_user(m_user),
	.rq_valid(rd.rq_valid), .rq_ready(rd.rq_ready), .rq_x(rd.rq_x), .rq_y(rd.rq_y),
	.rq_coeff(rd.rq_coeff), .rq_corner(rd.rq_corner)
);

//--- source/bilinear_top.sv
/*
 * Top level of the bilinear texture sampler.
 * Wires the config block, fetch, image memory and accumulator, and keeps the
 * sample tags in order in a four-entry FIFO. All ports are plain signals.
 */

`include "bilinear_params.svh"

module bilinear_top (
	input logic clk,
	input logic reset,
	input logic [`BL_COORD_WIDTH-1:0] s_x,
	input logic [`BL_COORD_WIDTH-1:0] s_y,
	input logic [`BL_USER_WIDTH-1:0] s_user,
	input logic s_valid,
	output logic s_ready,
	output logic [`BL_PIXEL_WIDTH-1:0] m_data,
	output logic [`BL_USER_WIDTH-1:0] m_user,
	output logic m_valid,
	input logic m_ready,
	input logic cfg_we,
	input bilinear_pkg::cfg_reg_t cfg_sel,
	input logic [`BL_INT_WIDTH:0] cfg_wdata,
	input logic tex_we,
	input logic [`BL_INT_WIDTH-1:0] tex_x,
	input logic [`BL_INT_WIDTH-1:0] tex_y,
	input logic [`BL_PIXEL_WIDTH-1:0] tex_wdata
);
	import bilinear_pkg::*;

	localparam int TAG_DEPTH = 4;
	localparam int TAG_PTR_W = $clog2(TAG_DEPTH);

	logic [`BL_INT_WIDTH:0] img_width;
	logic [`BL_INT_WIDTH:0] img_height;
	border_mode_t border_mode;

	logic tag_push;
	logic tag_pop;
	logic tag_full;
	logic [`BL_USER_WIDTH-1:0] tag_wr_data;
	logic [`BL_USER_WIDTH-1:0] tag_rd_data;
	logic [`BL_USER_WIDTH-1:0] tag_mem [TAG_DEPTH];
	logic [TAG_PTR_W:0] tag_wr_ptr;
	logic [TAG_PTR_W:0] tag_rd_ptr;

	texel_rd_if rd ();

	// --------------------------------------------------
	// tag FIFO, in order, fetch to accumulator
	// --------------------------------------------------
	// extra pointer bit tells full from empty
	assign tag_full = (tag_wr_ptr[TAG_PTR_W] != tag_rd_ptr[TAG_PTR_W])
		&& (tag_wr_ptr[TAG_PTR_W-1:0] == tag_rd_ptr[TAG_PTR_W-1:0]);
	assign tag_rd_data = tag_mem[tag_rd_ptr[TAG_PTR_W-1:0]];

	always_ff @(posedge clk) begin
		if (reset) begin
			tag_wr_ptr <= '0;
			tag_rd_ptr <= '0;
		end else begin
			if (tag_push) begin
				tag_wr_ptr <= tag_wr_ptr + 1'b1;
			end
			if (tag_pop) begin
				tag_rd_ptr <= tag_rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tag_push) begin
			tag_mem[tag_wr_ptr[TAG_PTR_W-1:0]] <= tag_wr_data;
		end
	end

	// --------------------------------------------------
	// sampler blocks
	// --------------------------------------------------
	bilinear_cfg cfg0 (
		.clk(clk), .reset(reset),
		.cfg_we(cfg_we), .cfg_sel(cfg_sel), .cfg_wdata(cfg_wdata),
		.img_width(img_width), .img_height(img_height), .border_mode(border_mode)
	);

	bilinear_fetch fetch0 (
		.clk(clk), .reset(reset),
		.s_x(s_x), .s_y(s_y), .s_user(s_user), .s_valid(s_valid), .s_ready(s_ready),
		.tag_push(tag_push), .tag_data(tag_wr_data), .tag_full(tag_full),
		.rd(rd.fetch)
	);

	texel_ram ram0 (
		.clk(clk), .reset(reset),
		.tex_we(tex_we), .tex_x(tex_x), .tex_y(tex_y), .tex_wdata(tex_wdata),
		.img_width(img_width), .img_height(img_height), .border_mode(border_mode),
		.rd(rd.mem)
	);

	bilinear_accum accum0 (
		.clk(clk), .reset(reset),
		.rd(rd.accum),
		.tag_pop(tag_pop), .tag_data(tag_rd_data),
		.m_data(m_data), .m_user(m_user), .m_valid(m_valid), .m_ready(m_ready)
	);

endmodule

//--- source/bilinear_accum.sv
/*
 * Weighted sum of the four texel responses of a sample.
 * Each component is multiplied by the corner weight and accumulated; the SE
 * beat loads the output register with the sum over 256 and the popped tag.
 * The output register holds its value while m_ready is low.
 */

`include "bilinear_params.svh"

module bilinear_accum (
	input logic clk,
	input logic reset,
	texel_rd_if.accum rd,
	output logic tag_pop,
	input logic [`BL_USER_WIDTH-1:0] tag_data,
	output logic [`BL_PIXEL_WIDTH-1:0] m_data,
	output logic [`BL_USER_WIDTH-1:0] m_user,
	output logic m_valid,
	input logic m_ready
);
	import bilinear_pkg::*;

	// 8-bit texel times 9-bit weight
	localparam int ACC_W = `BL_DATA_WIDTH + `BL_COEFF_WIDTH;
	// the four weights sum to 2^SHIFT
	localparam int SHIFT = 2 * `BL_FRAC_WIDTH;

	logic [ACC_W-1:0] acc [`BL_COMP_NUM];
	logic [ACC_W-1:0] sum [`BL_COMP_NUM];

	logic accept;
	logic first;
	logic last;

	// --------------------------------------------------
	// response handshake
	// --------------------------------------------------
	assign rd.rs_ready = !m_valid || m_ready;
	assign accept = rd.rs_valid && rd.rs_ready;

	assign first = (rd.rs_corner == CORNER_NW);
	assign last = (rd.rs_corner == CORNER_SE);

	// one tag leaves the FIFO per pixel
	assign tag_pop = accept && last;

	// --------------------------------------------------
	// multiply-add per component
	// --------------------------------------------------
	always_comb begin
		for (int i = 0; i < `BL_COMP_NUM; i++) begin
			sum[i] = ACC_W'(rd.rs_data[i*`BL_DATA_WIDTH +: `BL_DATA_WIDTH])
				* ACC_W'(rd.rs_coeff);
			// NW starts a new sample
			if (!first) begin
				sum[i] = sum[i] + acc[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			for (int i = 0; i < `BL_COMP_NUM; i++) begin
				acc[i] <= sum[i];
			end
		end
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			m_valid <= 1'b0;
		end else if (accept && last) begin
			m_valid <= 1'b1;
		end else if (m_ready) begin
			m_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && last) begin
			for (int i = 0; i < `BL_COMP_NUM; i++) begin
				m_data[i*`BL_DATA_WIDTH +: `BL_DATA_WIDTH] <= sum[i][SHIFT +: `BL_DATA_WIDTH];
			end
			m_user <= tag_data;
		end
	end

endmodule

//--- source/texel_ram.sv
/*
 * Image memory of 16 by 16 texels with a plain write port.
 * The read port takes one handshaked request per cycle and answers on the
 * next edge. Coordinates outside the active image follow the border mode.
 */

`include "bilinear_params.svh"

module texel_ram (
	input logic clk,
	input logic reset,
	input logic tex_we,
	input logic [`BL_INT_WIDTH-1:0] tex_x,
	input logic [`BL_INT_WIDTH-1:0] tex_y,
	input logic [`BL_PIXEL_WIDTH-1:0] tex_wdata,
	input logic [`BL_INT_WIDTH:0] img_width,
	input logic [`BL_INT_WIDTH:0] img_height,
	input bilinear_pkg::border_mode_t border_mode,
	texel_rd_if.mem rd
);
	import bilinear_pkg::*;

	localparam int DEPTH = 1 << (2 * `BL_INT_WIDTH);

	logic [`BL_PIXEL_WIDTH-1:0] mem [DEPTH];

	logic rq_xfer;
	logic x_out;
	logic y_out;
	logic [`BL_INT_WIDTH:0] col_last;
	logic [`BL_INT_WIDTH:0] row_last;
	logic [`BL_INT_WIDTH-1:0] col;
	logic [`BL_INT_WIDTH-1:0] row;
	logic zero_data;

	always_ff @(posedge clk) begin
		if (tex_we) begin
			mem[{tex_y, tex_x}] <= tex_wdata;
		end
	end

	// --------------------------------------------------
	// border rule
	// --------------------------------------------------
	assign x_out = rd.rq_x >= img_width;
	assign y_out = rd.rq_y >= img_height;
	assign col_last = img_width - 1'b1;
	assign row_last = img_height - 1'b1;

	// clamp to the last column or row
	assign col = x_out ? col_last[`BL_INT_WIDTH-1:0] : rd.rq_x[`BL_INT_WIDTH-1:0];
	assign row = y_out ? row_last[`BL_INT_WIDTH-1:0] : rd.rq_y[`BL_INT_WIDTH-1:0];
	assign zero_data = (border_mode == BORDER_ZERO) && (x_out || y_out);

	// --------------------------------------------------
	// read response
	// --------------------------------------------------
	// a held response blocks new requests
	assign rd.rq_ready = !rd.rs_valid || rd.rs_ready;
	assign rq_xfer = rd.rq_valid && rd.rq_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd.rs_valid <= 1'b0;
		end else if (rq_xfer) begin
			rd.rs_valid <= 1'b1;
		end else if (rd.rs_ready) begin
			rd.rs_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rq_xfer) begin
			rd.rs_data <= zero_data ? '0 : mem[{row, col}];
			rd.rs_coeff <= rd.rq_coeff;
			rd.rs_corner <= rd.rq_corner;
		end
	end

endmodule

//--- source/bilinear_fetch.sv
/*
 * Sample splitter of the bilinear sampler.
 * Registers one sample, then issues its four corner reads in NW, NE, SW, SE
 * order, each with the product of its horizontal and vertical weight.
 * Pushes the sample tag into the tag FIFO on accept.
 */

`include "bilinear_params.svh"

module bilinear_fetch (
	input logic clk,
	input logic reset,
	input logic [`BL_COORD_WIDTH-1:0] s_x,
	input logic [`BL_COORD_WIDTH-1:0] s_y,
	input logic [`BL_USER_WIDTH-1:0] s_user,
	input logic s_valid,
	output logic s_ready,
	output logic tag_push,
	output logic [`BL_USER_WIDTH-1:0] tag_data,
	input logic tag_full,
	texel_rd_if.fetch rd
);
	import bilinear_pkg::*;

	// weight of a whole texel step, 16 for four fraction bits
	localparam logic [`BL_FRAC_WIDTH:0] W_ONE = 1 << `BL_FRAC_WIDTH;

	logic busy;
	corner_t corner;
	logic [`BL_INT_WIDTH-1:0] x_int;
	logic [`BL_INT_WIDTH-1:0] y_int;
	logic [`BL_FRAC_WIDTH-1:0] x_frac;
	logic [`BL_FRAC_WIDTH-1:0] y_frac;

	logic accept;
	logic rq_xfer;
	logic last_corner;
	logic east;
	logic south;
	logic [`BL_FRAC_WIDTH:0] wx;
	logic [`BL_FRAC_WIDTH:0] wy;

	// --------------------------------------------------
	// sample handshake
	// --------------------------------------------------
	assign rq_xfer = rd.rq_valid && rd.rq_ready;
	assign last_corner = (corner == CORNER_SE);

	// idle, or finishing the SE read this cycle
	assign s_ready = !tag_full && (!busy || (rq_xfer && last_corner));
	assign accept = s_valid && s_ready;

	assign tag_push = accept;
	assign tag_data = s_user;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			corner <= CORNER_NW;
		end else if (accept) begin
			busy <= 1'b1;
			corner <= CORNER_NW;
		end else if (rq_xfer) begin
			if (last_corner) begin
				busy <= 1'b0;
			end
			corner <= corner_t'(corner + 1'b1);
		end
	end

	// coordinate split, held for all four reads
	always_ff @(posedge clk) begin
		if (accept) begin
			{x_int, x_frac} <= s_x;
			{y_int, y_frac} <= s_y;
		end
	end

	// --------------------------------------------------
	// corner request
	// --------------------------------------------------
	assign east = (corner == CORNER_NE) || (corner == CORNER_SE);
	assign south = (corner == CORNER_SW) || (corner == CORNER_SE);

	// far neighbour gets the fraction, near one the rest
	assign wx = east ? {1'b0, x_frac} : W_ONE - {1'b0, x_frac};
	assign wy = south ? {1'b0, y_frac} : W_ONE - {1'b0, y_frac};

	// x+1 and y+1 may reach 16, the memory applies the border
	assign rd.rq_x = {1'b0, x_int} + {{`BL_INT_WIDTH{1'b0}}, east};
	assign rd.rq_y = {1'b0, y_int} + {{`BL_INT_WIDTH{1'b0}}, south};
	assign rd.rq_coeff = `BL_COEFF_WIDTH'(wx) * `BL_COEFF_WIDTH'(wy);
	assign rd.rq_corner = corner;
	assign rd.rq_valid = busy;

endmodule

//--- source/bilinear_cfg.sv
/*
 * Register block for the image memory.
 * Holds the active width, height and border mode, written by a strobe.
 * Width and height are kept in the range 1 to 16.
 */

`include "bilinear_params.svh"

module bilinear_cfg (
	input logic clk,
	input logic reset,
	input logic cfg_we,
	input bilinear_pkg::cfg_reg_t cfg_sel,
	input logic [`BL_INT_WIDTH:0] cfg_wdata,
	output logic [`BL_INT_WIDTH:0] img_width,
	output logic [`BL_INT_WIDTH:0] img_height,
	output bilinear_pkg::border_mode_t border_mode
);
	import bilinear_pkg::*;

	// full side of the memory
	localparam logic [`BL_INT_WIDTH:0] IMG_MAX = 1 << `BL_INT_WIDTH;

	logic [`BL_INT_WIDTH:0] dim_sat;

	// an empty image is never allowed
	always_comb begin
		if (cfg_wdata == '0) begin
			dim_sat = 1;
		end else if (cfg_wdata > IMG_MAX) begin
			dim_sat = IMG_MAX;
		end else begin
			dim_sat = cfg_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			img_width <= IMG_MAX;
			img_height <= IMG_MAX;
			border_mode <= BORDER_CLAMP;
		end else if (cfg_we) begin
			case (cfg_sel)
				REG_WIDTH: img_width <= dim_sat;
				REG_HEIGHT: img_height <= dim_sat;
				REG_BORDER: border_mode <= border_mode_t'(cfg_wdata[0]);
				default: ;
			endcase
		end
	end

endmodule

//--- source/texel_rd_if.sv
/*
 * Texel read channel between fetch, memory and accumulator.
 * The request carries a neighbour coordinate and its weight, the response
 * returns the texel with the weight and corner passed along.
 */

`include "bilinear_params.svh"

interface texel_rd_if;
	import bilinear_pkg::*;

	// request, fetch to memory
	logic [`BL_INT_WIDTH:0] rq_x;
	logic [`BL_INT_WIDTH:0] rq_y;
	logic [`BL_COEFF_WIDTH-1:0] rq_coeff;
	corner_t rq_corner;
	logic rq_valid;
	logic rq_ready;

	// response, memory to accumulator
	logic [`BL_PIXEL_WIDTH-1:0] rs_data;
	logic [`BL_COEFF_WIDTH-1:0] rs_coeff;
	corner_t rs_corner;
	logic rs_valid;
	logic rs_ready;

	modport fetch (output rq_x, rq_y, rq_coeff, rq_corner, rq_valid, input rq_ready);
	modport mem (input rq_x, rq_y, rq_coeff, rq_corner, rq_valid, output rq_ready,
		output rs_data, rs_coeff, rs_corner, rs_valid, input rs_ready);
	modport accum (input rs_data, rs_coeff, rs_corner, rs_valid, output rs_ready);
endinterface

//--- source/bilinear_pkg.sv
/*
 * Shared types of the bilinear sampler.
 * Holds the corner order, the border modes and the register selects.
 * Modules import it inside their body; ports use scoped names.
 */

`include "bilinear_params.svh"

package bilinear_pkg;

	// --------------------------------------------------
	// corner order of the four reads of one sample
	// --------------------------------------------------
	// bit 0 selects the east column, bit 1 the south row
	typedef enum logic [1:0] {
		CORNER_NW,
		CORNER_NE,
		CORNER_SW,
		CORNER_SE
	} corner_t;

	// --------------------------------------------------
	// handling of neighbours outside the image
	// --------------------------------------------------
	typedef enum logic {
		BORDER_CLAMP,
		BORDER_ZERO
	} border_mode_t;

	// --------------------------------------------------
	// config register selects
	// --------------------------------------------------
	typedef enum logic [1:0] {
		REG_WIDTH,
		REG_HEIGHT,
		REG_BORDER
	} cfg_reg_t;

endpackage

//--- source/bilinear_params.svh
/*
 * Size macros for the bilinear texture sampler.
 * Coordinates are unsigned fixed point, integer part above fraction.
 * Include this file wherever a width is needed. The guard makes repeats harmless.
 */

`ifndef BILINEAR_PARAMS_SVH
`define BILINEAR_PARAMS_SVH

// coordinate format
`define BL_INT_WIDTH 4
`define BL_FRAC_WIDTH 4
`define BL_COORD_WIDTH 8

// texel format, component 0 in the low byte
`define BL_COMP_NUM 3
`define BL_DATA_WIDTH 8
`define BL_PIXEL_WIDTH 24

// corner weight 0..256, four of them sum to 256
`define BL_COEFF_WIDTH 9

// sample tag
`define BL_USER_WIDTH 8

`endif
